/* verilog.f */
source/scan_pkg.sv
source/video_if.sv
source/input_sync.sv
source/resync_indicator.sv
source/source_select.sv
source/tx_output.sv
source/board_top.sv
tb/board_top_assert.sv
tb/tb_board_top.sv

/* tb/tb_board_top.sv */
// testbench for board_top with seeded random stimulus checked against a queue-based model
`default_nettype none
`timescale 1ns/100ps

module tb_board_top
    import scan_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int HOLD_W       = 6;
    localparam int HOLD_CYCLES  = (1 << HOLD_W) - 1;
    localparam int RESET_CYCLES = 16;
    localparam int PHASES       = 12;
    localparam int PHASE_CYCLES = 100;
    // reset at start and once more before the middle phase
    localparam int TEST_CYCLES  = 2 * RESET_CYCLES + PHASES * PHASE_CYCLES;

    logic               clk27 = 1'b0;
    logic               po_reset_n;
    logic [CTRL_W-1:0]  sys_ctrl_i;
    logic [COLOR_W-1:0] isl_r_i, isl_g_i, isl_b_i;
    logic [COLOR_W-1:0] hdmirx_r_i, hdmirx_g_i, hdmirx_b_i;
    logic               isl_hsync_i, isl_vsync_i, isl_de_i, isl_fid_i;
    logic               hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i;
    logic               pcm_bck_i, pcm_ws_i, pcm_data_i;
    logic               hdmirx_bck_i, hdmirx_ws_i, hdmirx_ap_i;
    logic [BTN_W-1:0]   btn_i;
    logic               ir_rx_i, resync_strobe_i;
    logic [COLOR_W-1:0] hdmitx_r_o, hdmitx_g_o, hdmitx_b_o;
    logic               hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o;
    logic               hdmitx_bck_o, hdmitx_ws_o, hdmitx_data_o;
    logic [LED_W-1:0]   led_o;
    sys_status_t        status_o;
    logic               isl_reset_n_o, hdmirx_reset_n_o, audmux_o;

    // expected video and status run two cycles deep and audio one
    pixel_t      video_q[$];
    i2s_t        audio_q[$];
    sys_status_t status_q[$];
    int          cycle_n     = 0;
    // drive cycle of the last strobe rise or far in the past when none
    int          last_rise   = -100000;
    logic        strobe_prev = 1'b0;
    int          check_count = 0;
    int          error_count = 0;

    board_top #(.led_hold_w(HOLD_W)) DUT (.*);

    always #(CLK_PERIOD / 2) clk27 = ~clk27;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // runs 1 ns after the rising edge while inputs still hold last cycle's values
    task automatic check_outputs();
        pixel_t      exp_pix;
        i2s_t        exp_aud;
        sys_status_t exp_st;
        int          age;
        exp_pix = video_q.pop_front();
        exp_aud = audio_q.pop_front();
        exp_st  = status_q.pop_front();
        age     = cycle_n - last_rise;
        // asynchronous reset clears the stages at once
        if (!po_reset_n) begin
            exp_pix = '0;
            exp_st  = '1;
        end
        // gating uses power-on at the last falling edge
        if (!sys_ctrl_i[0]) begin
            exp_pix = '0;
        end
        check_value("hdmitx_r_o", hdmitx_r_o, exp_pix.red);
        check_value("hdmitx_g_o", hdmitx_g_o, exp_pix.green);
        check_value("hdmitx_b_o", hdmitx_b_o, exp_pix.blue);
        check_value("hdmitx_hsync_o", hdmitx_hsync_o, exp_pix.hsync);
        check_value("hdmitx_vsync_o", hdmitx_vsync_o, exp_pix.vsync);
        check_value("hdmitx_de_o", hdmitx_de_o, exp_pix.de);
        check_value("hdmitx_bck_o", hdmitx_bck_o, exp_aud.bck);
        check_value("hdmitx_ws_o", hdmitx_ws_o, exp_aud.ws);
        check_value("hdmitx_data_o", hdmitx_data_o, exp_aud.data);
        check_value("status_o", status_o, exp_st);
        check_value("audmux_o", audmux_o, !sys_ctrl_i[8]);
        check_value("isl_reset_n_o", isl_reset_n_o, sys_ctrl_i[1]);
        check_value("hdmirx_reset_n_o", hdmirx_reset_n_o, sys_ctrl_i[2]);
        if (!sys_ctrl_i[0]) begin
            check_value("led_o", led_o, LED_OFF_PATTERN);
        end else begin
            check_value("led_o[2]", led_o[2], ~&exp_st.btn);
            check_value("led_o[1]", led_o[1], !exp_st.ir_rx);
            // sync delay and counter end leave a few cycles unchecked
            if (age >= 5 && age <= HOLD_CYCLES - 3) begin
                check_value("led_o[0]", led_o[0], 1'b1);
            end else if (age >= HOLD_CYCLES + 3) begin
                check_value("led_o[0]", led_o[0], 1'b0);
            end
        end
    endtask

    // model follows the values just driven, which the DUT takes at the next edge
    task automatic update_model();
        pixel_t isl_pix;
        pixel_t rx_pix;
        i2s_t   pcm_aud;
        i2s_t   rx_aud;
        isl_pix = {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i, isl_fid_i};
        rx_pix  = {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i,
                   hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i, 1'b0};
        pcm_aud = {pcm_bck_i, pcm_ws_i, pcm_data_i};
        rx_aud  = {hdmirx_bck_i, hdmirx_ws_i, hdmirx_ap_i};
        if (!po_reset_n) begin
            video_q.push_back('0);
            audio_q.push_back('0);
            status_q.push_back('1);
            last_rise = -100000;
        end else begin
            video_q.push_back(sys_ctrl_i[5] ? rx_pix : isl_pix);
            audio_q.push_back(sys_ctrl_i[8] ? rx_aud : pcm_aud);
            status_q.push_back({btn_i, ir_rx_i});
            if (resync_strobe_i && !strobe_prev) begin
                last_rise = cycle_n;
            end
        end
        strobe_prev = resync_strobe_i;
    endtask

    task automatic run_cycle(input logic rst_n, input logic poweron, input logic capture_sel,
                             input logic strobe);
        @(posedge clk27);
        #1;
        check_outputs();
        #4;
        po_reset_n     = rst_n;
        sys_ctrl_i     = $urandom;
        sys_ctrl_i[0]  = poweron;
        sys_ctrl_i[5]  = capture_sel;
        {isl_r_i, isl_g_i, isl_b_i} = $urandom;
        {isl_hsync_i, isl_vsync_i, isl_de_i, isl_fid_i} = $urandom;
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i} = $urandom;
        {hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i} = $urandom;
        {pcm_bck_i, pcm_ws_i, pcm_data_i, hdmirx_bck_i, hdmirx_ws_i, hdmirx_ap_i} = $urandom;
        {btn_i, ir_rx_i} = $urandom;
        resync_strobe_i = strobe;
        update_model();
        cycle_n++;
    endtask

    // strobe stays low so no rise hides in the synchronizer across reset
    task automatic run_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            run_cycle(1'b0, 1'($urandom), 1'($urandom), 1'b0);
        end
    endtask

    task automatic run_phase(input int p);
        logic poweron;
        logic capture_sel;
        logic pulse;
        int   offset;
        poweron     = ($urandom % 4) != 0;
        capture_sel = 1'($urandom);
        pulse       = 1'($urandom);
        offset      = $urandom % 20;
        // first phase always lights the resync LED and the second always blanks
        if (p == 0) begin
            poweron = 1'b1;
            pulse   = 1'b1;
        end else if (p == 1) begin
            poweron = 1'b0;
        end
        for (int i = 0; i < PHASE_CYCLES; i++) begin
            run_cycle(1'b1, poweron, capture_sel, pulse && i >= offset && i < offset + 2);
        end
    endtask

    initial begin
        void'($urandom(17721));
        po_reset_n = 1'b1;
        sys_ctrl_i = '0;
        {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i, isl_fid_i} = '0;
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i, hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i} = '0;
        {pcm_bck_i, pcm_ws_i, pcm_data_i, hdmirx_bck_i, hdmirx_ws_i, hdmirx_ap_i} = '0;
        {btn_i, ir_rx_i, resync_strobe_i} = '0;
        // reset drops just after time zero so every reset flop sees the falling edge
        #1;
        po_reset_n = 1'b0;
        // DUT starts in reset, so the first checks expect reset values
        repeat (2) begin
            video_q.push_back('0);
            status_q.push_back('1);
        end
        audio_q.push_back('0);
        run_reset();
        for (int p = 0; p < PHASES; p++) begin
            if (p == PHASES / 2) begin
                run_reset();
            end
            run_phase(p);
        end
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, DUT.u_assert.fail_count);
        if (error_count == 0 && DUT.u_assert.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + 200) * CLK_PERIOD);
        $display("error: run timed out after %0d cycles", TEST_CYCLES + 200);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/board_top_assert.sv */
// concurrent property checks on board_top attached to every board_top instance through bind
`default_nettype none
`timescale 1ns/100ps

module board_top_assert
    import scan_pkg::*;
(
    input wire logic               clk27,
    input wire logic               po_reset_n,
    input wire logic [CTRL_W-1:0]  sys_ctrl_i,
    input wire logic [LED_W-1:0]   led_o,
    input wire logic [COLOR_W-1:0] hdmitx_r_o,
    input wire logic [COLOR_W-1:0] hdmitx_g_o,
    input wire logic [COLOR_W-1:0] hdmitx_b_o,
    input wire logic               hdmitx_hsync_o,
    input wire logic               hdmitx_vsync_o,
    input wire logic               hdmitx_de_o,
    input wire logic               audmux_o,
    input wire logic               resync_rise
);

    sys_ctrl_t   ctrl;
    logic        video_zero;
    // number of failed properties so far
    int unsigned fail_count = 0;

    assign ctrl = sys_ctrl_t'(sys_ctrl_i);
    assign video_zero = ({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} == '0) &&
                        !hdmitx_hsync_o && !hdmitx_vsync_o && !hdmitx_de_o;

    // standby pattern holds in and out of reset
    led_off_check: assert property (@(posedge clk27) !ctrl.poweron |-> led_o == LED_OFF_PATTERN)
        else begin
            $error("led_o is not the standby pattern while power-on is low");
            fail_count++;
        end

    // blanking reaches the pins by the next falling edge
    blank_check: assert property (@(posedge clk27) disable iff (!po_reset_n)
        $fell(ctrl.poweron) ##1 !ctrl.poweron |-> video_zero)
        else begin
            $error("video outputs not blanked one cycle after power-on fell");
            fail_count++;
        end

    rise_pulse_check: assert property (@(posedge clk27) disable iff (!po_reset_n)
        resync_rise |=> !resync_rise)
        else begin
            $error("resync rise pulse lasted more than one cycle");
            fail_count++;
        end

    audmux_check: assert property (@(posedge clk27) audmux_o == !ctrl.audmux_sel)
        else begin
            $error("audmux_o is not the inverse of the audio mux select");
            fail_count++;
        end

endmodule

bind board_top board_top_assert u_assert (
    .clk27          (clk27),
    .po_reset_n     (po_reset_n),
    .sys_ctrl_i     (sys_ctrl_i),
    .led_o          (led_o),
    .hdmitx_r_o     (hdmitx_r_o),
    .hdmitx_g_o     (hdmitx_g_o),
    .hdmitx_b_o     (hdmitx_b_o),
    .hdmitx_hsync_o (hdmitx_hsync_o),
    .hdmitx_vsync_o (hdmitx_vsync_o),
    .hdmitx_de_o    (hdmitx_de_o),
    .audmux_o       (audmux_o),
    .resync_rise    (resync_rise)
);

`default_nettype wire

/* source/board_top.sv */
// board glue top level: control word decode, input sync, LEDs, video/audio select, tx pins
`default_nettype none
`timescale 1ns/100ps

module board_top
    import scan_pkg::*;
#(
    parameter int led_hold_w = LED_HOLD_W_DEFAULT
) (
    input  wire logic               clk27,
    input  wire logic               po_reset_n,
    input  wire logic [CTRL_W-1:0]  sys_ctrl_i,

    // analog digitizer video
    input  wire logic [COLOR_W-1:0] isl_r_i,
    input  wire logic [COLOR_W-1:0] isl_g_i,
    input  wire logic [COLOR_W-1:0] isl_b_i,
    input  wire logic               isl_hsync_i,
    input  wire logic               isl_vsync_i,
    input  wire logic               isl_de_i,
    input  wire logic               isl_fid_i,

    // HDMI receiver video
    input  wire logic [COLOR_W-1:0] hdmirx_r_i,
    input  wire logic [COLOR_W-1:0] hdmirx_g_i,
    input  wire logic [COLOR_W-1:0] hdmirx_b_i,
    input  wire logic               hdmirx_hsync_i,
    input  wire logic               hdmirx_vsync_i,
    input  wire logic               hdmirx_de_i,

    // audio sources
    input  wire logic               pcm_bck_i,
    input  wire logic               pcm_ws_i,
    input  wire logic               pcm_data_i,
    input  wire logic               hdmirx_bck_i,
    input  wire logic               hdmirx_ws_i,
    input  wire logic               hdmirx_ap_i,

    input  wire logic [BTN_W-1:0]   btn_i,
    input  wire logic               ir_rx_i,
    input  wire logic               resync_strobe_i,

    // HDMI transmitter
    output logic      [COLOR_W-1:0] hdmitx_r_o,
    output logic      [COLOR_W-1:0] hdmitx_g_o,
    output logic      [COLOR_W-1:0] hdmitx_b_o,
    output logic                    hdmitx_hsync_o,
    output logic                    hdmitx_vsync_o,
    output logic                    hdmitx_de_o,
    output logic                    hdmitx_bck_o,
    output logic                    hdmitx_ws_o,
    output logic                    hdmitx_data_o,

    output logic      [LED_W-1:0]   led_o,
    output sys_status_t             status_o,
    output logic                    isl_reset_n_o,
    output logic                    hdmirx_reset_n_o,
    output logic                    audmux_o
);

    sys_ctrl_t        ctrl;
    pixel_t           isl_pix;
    pixel_t           hdmirx_pix;
    i2s_t             pcm_aud;
    i2s_t             hdmirx_aud;
    i2s_t             tx_aud;
    logic [BTN_W-1:0] btn_sync;
    logic             ir_sync;
    logic             resync_rise;

    video_if vid ();

    // named view of the host control word
    assign ctrl = sys_ctrl_t'(sys_ctrl_i);

    // reset pins go straight out, no registering
    assign isl_reset_n_o    = ctrl.isl_reset_n;
    assign hdmirx_reset_n_o = ctrl.hdmirx_reset_n;
    // external audio mux select is active low on the board
    assign audmux_o         = ~ctrl.audmux_sel;

    // pack capture pins, the receiver has no field id output
    assign isl_pix    = '{red: isl_r_i, green: isl_g_i, blue: isl_b_i,
                          hsync: isl_hsync_i, vsync: isl_vsync_i,
                          de: isl_de_i, fid: isl_fid_i};
    assign hdmirx_pix = '{red: hdmirx_r_i, green: hdmirx_g_i, blue: hdmirx_b_i,
                          hsync: hdmirx_hsync_i, vsync: hdmirx_vsync_i,
                          de: hdmirx_de_i, fid: 1'b0};

    assign pcm_aud    = '{bck: pcm_bck_i, ws: pcm_ws_i, data: pcm_data_i};
    // receiver audio data comes out on its AP pin
    assign hdmirx_aud = '{bck: hdmirx_bck_i, ws: hdmirx_ws_i, data: hdmirx_ap_i};

    input_sync u_input_sync (
        .clk27           (clk27),
        .po_reset_n      (po_reset_n),
        .btn_i           (btn_i),
        .ir_rx_i         (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .btn_sync_o      (btn_sync),
        .ir_sync_o       (ir_sync),
        .resync_rise_o   (resync_rise)
    );

    resync_indicator #(
        .hold_w (led_hold_w)
    ) u_resync_indicator (
        .clk27         (clk27),
        .po_reset_n    (po_reset_n),
        .resync_rise_i (resync_rise),
        .poweron_i     (ctrl.poweron),
        .btn_sync_i    (btn_sync),
        .ir_sync_i     (ir_sync),
        .led_o         (led_o)
    );

    // status word read back by the host
    assign status_o = '{btn: btn_sync, ir_rx: ir_sync};

    // digitizer on 0, HDMI receiver on 1
    source_select #(
        .payload_t (pixel_t)
    ) u_video_select (
        .clk27      (clk27),
        .po_reset_n (po_reset_n),
        .sel_i      (ctrl.capture_sel),
        .a_i        (isl_pix),
        .b_i        (hdmirx_pix),
        .sel_o      (vid.data)
    );

    // PCM on 0, HDMI receiver on 1
    source_select #(
        .payload_t (i2s_t)
    ) u_audio_select (
        .clk27      (clk27),
        .po_reset_n (po_reset_n),
        .sel_i      (ctrl.audmux_sel),
        .a_i        (pcm_aud),
        .b_i        (hdmirx_aud),
        .sel_o      (tx_aud)
    );

    assign hdmitx_bck_o  = tx_aud.bck;
    assign hdmitx_ws_o   = tx_aud.ws;
    assign hdmitx_data_o = tx_aud.data;

    tx_output u_tx_output (
        .clk27      (clk27),
        .po_reset_n (po_reset_n),
        .poweron_i  (ctrl.poweron),
        .pix        (vid.dst),
        .r_o        (hdmitx_r_o),
        .g_o        (hdmitx_g_o),
        .b_o        (hdmitx_b_o),
        .hsync_o    (hdmitx_hsync_o),
        .vsync_o    (hdmitx_vsync_o),
        .de_o       (hdmitx_de_o)
    );

endmodule

`default_nettype wire

/* source/tx_output.sv */
// falling-edge output register for the HDMI transmitter video pins, blanked when powered down
`default_nettype none
`timescale 1ns/100ps

module tx_output
    import scan_pkg::*;
(
    input  wire logic               clk27,
    input  wire logic               po_reset_n,
    input  wire logic               poweron_i,
    video_if.dst                    pix,
    output logic      [COLOR_W-1:0] r_o,
    output logic      [COLOR_W-1:0] g_o,
    output logic      [COLOR_W-1:0] b_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    de_o
);

    // pixel after power gating, fid is not sent to the transmitter
    pixel_t pix_gated;

    always_comb begin
        if (poweron_i) begin
            pix_gated = pix.data;
        end else begin
            pix_gated = '0;
        end
    end

    // launched on the falling edge so the transmitter samples
    // mid-cycle on the rising edge of the clock it receives
    always_ff @(negedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            r_o     <= pix_gated.red;
            g_o     <= pix_gated.green;
            b_o     <= pix_gated.blue;
            hsync_o <= pix_gated.hsync;
            vsync_o <= pix_gated.vsync;
            de_o    <= pix_gated.de;
        end
    end

endmodule

`default_nettype wire

/* source/source_select.sv */
// registered 2:1 source select, payload type set per instance (video pixel or i2s audio)
`default_nettype none
`timescale 1ns/100ps

module source_select
    import scan_pkg::*;
#(
    // any packed payload; pixel is the common case
    parameter type payload_t = pixel_t
) (
    input  wire logic     clk27,
    input  wire logic     po_reset_n,
    // 0 picks a_i, 1 picks b_i
    input  wire logic     sel_i,
    input  wire payload_t a_i,
    input  wire payload_t b_i,
    output payload_t      sel_o
);

    payload_t sel_next;

    // mux ahead of the register so the output is glitch free
    always_comb begin
        if (sel_i) begin
            sel_next = b_i;
        end else begin
            sel_next = a_i;
        end
    end

    // reset to all zeros so downstream pins come up quiet
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sel_o <= '0;
        end else begin
            sel_o <= sel_next;
        end
    end

endmodule

`default_nettype wire

/* source/resync_indicator.sv */
// resync hold counter and front panel LED pattern, driven from synchronized inputs
`default_nettype none
`timescale 1ns/100ps

module resync_indicator
    import scan_pkg::*;
#(
    // hold time is 2**hold_w - 1 cycles after the last resync
    parameter int hold_w = LED_HOLD_W_DEFAULT
) (
    input  wire logic             clk27,
    input  wire logic             po_reset_n,
    input  wire logic             resync_rise_i,
    input  wire logic             poweron_i,
    input  wire logic [BTN_W-1:0] btn_sync_i,
    input  wire logic             ir_sync_i,
    output logic      [LED_W-1:0] led_o
);

    logic [hold_w-1:0] hold_cnt;
    logic              hold_active;
    logic              ir_active;
    logic              btn_pressed;

    // retrigger on every resync, otherwise count down and stop at zero
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_cnt <= '0;
        end else if (resync_rise_i) begin
            hold_cnt <= '1;
        end else if (hold_active) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign hold_active = (hold_cnt != '0);

    // IR receiver output is active low, a low level means a burst is arriving
    assign ir_active = ~ir_sync_i;

    // buttons are active low, any one held lights the top LED
    assign btn_pressed = ~&btn_sync_i;

    // bit 0 resync, bit 1 IR activity, bit 2 button
    // powered down shows the fixed standby pattern instead
    always_comb begin
        if (poweron_i) begin
            led_o = {btn_pressed, ir_active, hold_active};
        end else begin
            led_o = LED_OFF_PATTERN;
        end
    end

endmodule

`default_nettype wire

/* source/input_sync.sv */
// two-stage synchronizers for buttons, IR line and resync strobe, with strobe rise detect
`default_nettype none
`timescale 1ns/100ps

module input_sync
    import scan_pkg::*;
(
    input  wire logic             clk27,
    input  wire logic             po_reset_n,
    input  wire logic [BTN_W-1:0] btn_i,
    input  wire logic             ir_rx_i,
    input  wire logic             resync_strobe_i,
    output logic      [BTN_W-1:0] btn_sync_o,
    output logic                  ir_sync_o,
    output logic                  resync_rise_o
);

    // first and second flop of each synchronizer
    logic [BTN_W-1:0] btn_meta;
    logic [BTN_W-1:0] btn_sync;
    logic             ir_meta;
    logic             ir_sync;
    logic             strobe_meta;
    logic             strobe_sync;
    // previous synchronized strobe for edge detect
    logic             strobe_prev;

    // buttons and IR idle high, so they reset to the released state
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_meta <= '1;
            btn_sync <= '1;
            ir_meta  <= 1'b1;
            ir_sync  <= 1'b1;
        end else begin
            btn_meta <= btn_i;
            btn_sync <= btn_meta;
            ir_meta  <= ir_rx_i;
            ir_sync  <= ir_meta;
        end
    end

    // strobe idles low; third flop holds last cycle's synchronized level
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_meta <= 1'b0;
            strobe_sync <= 1'b0;
            strobe_prev <= 1'b0;
        end else begin
            strobe_meta <= resync_strobe_i;
            strobe_sync <= strobe_meta;
            strobe_prev <= strobe_sync;
        end
    end

    assign btn_sync_o = btn_sync;
    assign ir_sync_o  = ir_sync;

    // one-cycle pulse per synchronized low-to-high transition
    assign resync_rise_o = strobe_sync & ~strobe_prev;

endmodule

`default_nettype wire

/* source/video_if.sv */
// carries the selected pixel from the capture select to the transmitter output stage
`default_nettype none
`timescale 1ns/100ps

interface video_if
    import scan_pkg::*;
();

    // registered pixel with syncs, de and field id
    pixel_t data;

    // driven by the capture select register
    modport src (
        output data
    );

    // read by the transmitter output register
    modport dst (
        input data
    );

endinterface

`default_nettype wire

/* source/scan_pkg.sv */
// shared widths, payload types and control/status word layouts; import into every RTL unit
`default_nettype none

package scan_pkg;

    // bits per color channel on both capture paths and the transmitter
    localparam int COLOR_W = 8;

    // system control word from the host register
    localparam int CTRL_W = 16;

    // front panel buttons, active low
    localparam int BTN_W = 2;

    // board LEDs
    localparam int LED_W = 3;

    // resync hold counter width, roughly half a second at 27 MHz
    localparam int LED_HOLD_W_DEFAULT = 24;

    // only the first LED lit while the board is powered down
    localparam logic [LED_W-1:0] LED_OFF_PATTERN = 3'b001;

    // one pixel with its timing signals
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
        logic               hsync;
        logic               vsync;
        logic               de;
        // field id, only meaningful for interlaced sources
        logic               fid;
    } pixel_t;

    // i2s audio lines
    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } i2s_t;

    // control word, msb first
    // reserved bits belong to functions not present in this build
    typedef struct packed {
        logic [6:0] rsvd_15_9;
        logic       audmux_sel;
        logic [1:0] rsvd_7_6;
        logic       capture_sel;
        logic [1:0] rsvd_4_3;
        logic       hdmirx_reset_n;
        logic       isl_reset_n;
        logic       poweron;
    } sys_ctrl_t;

    // status word returned to the host
    typedef struct packed {
        logic [BTN_W-1:0] btn;
        logic             ir_rx;
    } sys_status_t;

endpackage

`default_nettype wire
